/* bench/sd_host_tasks.svh */
/*
 * Host side of the SD bus
 * Command frames, response and block capture, CRC7 and CRC16
 */
`ifndef SD_HOST_TASKS_SVH
`define SD_HOST_TASKS_SVH

// x^7 + x^3 + 1 over the low nbits, MSB first
function automatic logic [6:0] crc7_of(input logic [127:0] bits, input int nbits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = nbits - 1; i >= 0; i--) begin
        fb = c[6] ^ bits[i];
        c  = {c[5:0], 1'b0};
        if (fb) begin
            c = c ^ 7'h09;
        end
    end
    return c;
endfunction

function automatic logic [15:0] crc16_step(input logic [15:0] c, input logic b);
    logic fb;
    fb = c[15] ^ b;
    return fb ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
endfunction

task automatic next_cycle();
    @(posedge sdclk);
    #10;
endtask

task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg, input logic bad_crc);
    logic [39:0] head;
    logic [47:0] frame;
    head   = {2'b01, index, arg};
    frame  = {head, crc7_of(128'(head), 40) ^ {6'd0, bad_crc}, 1'b1};
    cmd_in = 1'b1;
    repeat (8) next_cycle();                    // Card may still be ending a response
    for (int i = 47; i >= 0; i--) begin
        cmd_in = frame[i];
        next_cycle();
    end
    cmd_in = 1'b1;
endtask

task automatic capture_resp(input int nbits, input int timeout);
    resp_seen  = 1'b0;
    resp_bits  = '0;
    resp_delay = 0;
    while (!resp_seen && resp_delay < timeout) begin
        next_cycle();
        resp_delay++;
        resp_seen = cmd_oe && !cmd_out;
    end
    if (resp_seen) begin
        for (int i = 1; i < nbits; i++) begin
            next_cycle();
            resp_bits = {resp_bits[134:0], cmd_out};
        end
    end
endtask

// Unused lanes stay high on a 1-bit bus
task automatic track_upper_lanes();
    if (dat_out[3:1] !== 3'b111) begin
        blk_upper = dat_out[3:1];
    end
endtask

task automatic capture_block(input int timeout);
    int n;
    n            = 0;
    blk_seen     = 1'b0;
    blk_crc_calc = '0;
    blk_upper    = 3'b111;
    while (!blk_seen && n < timeout) begin
        next_cycle();
        n++;
        blk_seen = dat_oe && !dat_out[0];
    end
    if (blk_seen) begin
        track_upper_lanes();
        for (int i = 0; i < `SD_BLOCK_BYTES * 8; i++) begin
            next_cycle();
            blk[i / 8]   = {blk[i / 8][6:0], dat_out[0]};
            blk_crc_calc = crc16_step(blk_crc_calc, dat_out[0]);
            track_upper_lanes();
        end
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            blk_crc = {blk_crc[14:0], dat_out[0]};
            track_upper_lanes();
        end
        next_cycle();
        blk_end = dat_out[0];
        track_upper_lanes();
    end
endtask

task automatic command(input logic [5:0] index, input logic [31:0] arg, input int nbits);
    send_cmd(index, arg, 1'b0);
    capture_resp(nbits, 100);
    assert (resp_seen) else note_failure($sformatf("no response to CMD%0d", index));
endtask

`endif

/* bench/tb_sd_fake.sv */
/*
 * Testbench for the read-only SD card model
 * Drives host commands and checks responses and a block read
 */
`timescale 1ns/1ps
`include "sd_settings.svh"

module tb_sd_fake
    import sd_card_pkg::*;
();

    localparam logic [3:0]  STATE_STBY = 4'd3;   // SD current_state encoding
    localparam logic [3:0]  STATE_TRAN = 4'd4;
    localparam logic [31:0] RCA_ARG    = {`SD_RCA, 16'h0000};

    logic       sdclk = 1'b0;
    logic       rstn_sdclk_p;
    logic       cmd_in;
    logic       cmd_out;
    logic       cmd_oe;
    logic [3:0] dat_out;
    logic       dat_oe;
    logic       rdreq;
    ram_addr_t  rdaddr;
    ram_word_t  rddata = '0;

    logic       pend = 1'b0;
    ram_addr_t  pend_addr;
    ram_addr_t  addr_seen[$];

    // Captured bus traffic
    logic [135:0] resp_bits;
    logic         resp_seen;
    int           resp_delay;
    logic [7:0]   blk [`SD_BLOCK_BYTES];
    logic [15:0]  blk_crc;
    logic [15:0]  blk_crc_calc;
    logic         blk_end;
    logic         blk_seen;
    logic [2:0]   blk_upper;

    integer      seed;
    logic [31:0] sector;
    int          test_errors = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    sd_fake_top u_dut (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .cmd_in       (cmd_in),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .dat_out      (dat_out),
        .dat_oe       (dat_oe),
        .rdreq        (rdreq),
        .rdaddr       (rdaddr),
        .rddata       (rddata)
    );

    always #50 sdclk = ~sdclk;

    // RAM model, data one cycle after the request
    always @(posedge sdclk) begin
        #10;
        if (pend) begin
            rddata = pend_addr[15:0] ^ 16'ha5c3;
        end
        pend      = rdreq;
        pend_addr = rdaddr;
        if (rdreq) begin
            addr_seen.push_back(rdaddr);
        end
    end

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %-24s %0d errors", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    `include "sd_host_tasks.svh"

    // Framing of a 48-bit response
    task automatic check_short(input logic [5:0] index, input logic ones_crc);
        logic [6:0] crc;
        crc = ones_crc ? 7'h7f : crc7_of(128'(resp_bits[47:8]), 40);
        if (resp_seen) begin
            expect_equal("resp transmission bit", 128'(resp_bits[46]), 128'(0));
            expect_equal("resp index", 128'(resp_bits[45:40]), 128'(index));
            expect_equal("resp crc7", 128'(resp_bits[7:1]), 128'(crc));
            expect_equal("resp end bit", 128'(resp_bits[0]), 128'(1));
        end
    endtask

    initial begin
        ram_addr_t   exp_addr;
        logic [15:0] exp_word;
        logic [7:0]  exp_byte;
        seed         = 32'hd0eba058;
        rstn_sdclk_p = 1'b0;
        cmd_in       = 1'b1;
        repeat (8) @(posedge sdclk);
        #10;
        rstn_sdclk_p = 1'b1;

        // Tests --------------
        for (int i = 0; i < 20; i++) begin
            expect_equal("cmd_oe", 128'(cmd_oe), 128'(0));
            expect_equal("dat_oe", 128'(dat_oe), 128'(0));
            expect_equal("rdreq", 128'(rdreq), 128'(0));
            next_cycle();
        end
        finish_test("idle after reset");

        command(6'd8, 32'h0000_01aa, 48);            // Voltage 1, check byte 0xaa
        check_short(6'd8, 1'b0);
        expect_equal("R7 payload", 128'(resp_bits[39:8]), 128'(32'h0000_01aa));
        expect_equal("start bit delay", 128'(resp_delay + 1), 128'(1 + 1 + `SD_RESP_GAP + 1));
        finish_test("CMD8 R7");

        send_cmd(6'd8, 32'h0000_01aa, 1'b1);
        capture_resp(48, 200);
        assert (!resp_seen) else note_failure("response to a frame with a bad CRC7");
        finish_test("CMD8 bad CRC7");

        command(6'd55, 32'h0, 48);
        check_short(6'd55, 1'b0);
        command(6'd41, 32'h40ff_8000, 48);
        check_short(6'h3f, 1'b1);
        expect_equal("R3 OCR", 128'(resp_bits[39:8]), 128'(`SD_OCR));
        command(6'd2, 32'h0, 136);
        expect_equal("R2 index", 128'(resp_bits[133:128]), 128'(0));
        expect_equal("R2 CID", 128'(resp_bits[127:8]), 128'(`SD_CID));
        expect_equal("R2 crc7", 128'(resp_bits[7:1]), 128'(crc7_of(resp_bits[135:8], 128)));
        expect_equal("R2 end bit", 128'(resp_bits[0]), 128'(1));
        command(6'd3, 32'h0, 48);
        check_short(6'd3, 1'b0);
        expect_equal("R6 RCA", 128'(resp_bits[39:24]), 128'(`SD_RCA));
        command(6'd7, RCA_ARG, 48);
        check_short(6'd7, 1'b0);
        expect_equal("status current_state", 128'(resp_bits[20:17]), 128'(STATE_STBY));
        command(6'd13, RCA_ARG, 48);
        check_short(6'd13, 1'b0);
        expect_equal("status current_state", 128'(resp_bits[20:17]), 128'(STATE_TRAN));
        finish_test("init and select");

        sector = $random(seed);
        addr_seen.delete();
        send_cmd(6'd17, sector, 1'b0);
        fork
            capture_resp(48, 100);
            capture_block(200);
        join
        assert (resp_seen) else note_failure("no response to CMD17");
        check_short(6'd17, 1'b0);
        assert (blk_seen) else note_failure("no data start bit on dat[0]");
        if (blk_seen) begin
            for (int j = 0; j < `SD_BLOCK_BYTES; j++) begin
                exp_addr = {sector, 8'(j / 2)};        // Sector * 256 + word
                exp_word = exp_addr[15:0] ^ 16'ha5c3;
                exp_byte = (j % 2 == 0) ? exp_word[7:0] : exp_word[15:8];
                expect_equal($sformatf("dat[0] byte %0d", j), 128'(blk[j]), 128'(exp_byte));
            end
            expect_equal("dat[0] crc16", 128'(blk_crc), 128'(blk_crc_calc));
            expect_equal("dat[0] end bit", 128'(blk_end), 128'(1));
            expect_equal("dat_out[3:1]", 128'(blk_upper), 128'(3'b111));
        end
        expect_equal("rdreq count", 128'(addr_seen.size()), 128'(`SD_BLOCK_BYTES / 2));
        for (int k = 0; k < addr_seen.size() && k < `SD_BLOCK_BYTES / 2; k++) begin
            expect_equal("rdaddr", 128'(addr_seen[k]), 128'({sector, 8'(k)}));
        end
        command(6'd13, RCA_ARG, 48);
        expect_equal("status current_state", 128'(resp_bits[20:17]), 128'(STATE_TRAN));
        finish_test("CMD17 block read");

        send_cmd(6'd5, 32'h0, 1'b0);
        capture_resp(48, 200);
        assert (!resp_seen) else note_failure("response to the illegal CMD5");
        command(6'd13, RCA_ARG, 48);
        check_short(6'd13, 1'b0);
        expect_equal("status illegal_command", 128'(resp_bits[30]), 128'(1));
        command(6'd13, RCA_ARG, 48);
        expect_equal("status illegal_command", 128'(resp_bits[30]), 128'(0));
        finish_test("illegal command");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+source
+incdir+bench
source/sd_proto_pkg.sv
source/sd_card_pkg.sv
source/sd_resp_if.sv
source/sd_cmd_receiver.sv
source/sd_card_ctrl.sv
source/sd_resp_serializer.sv
source/sd_block_reader.sv
source/sd_fake_top.sv
bench/tb_sd_fake.sv

/* run_sim.sh */
#!/bin/sh
# Build the SD card model testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_sd_fake -o sim_sd_fake

out=$(./obj_dir/sim_sd_fake)
echo "$out"

# Exit status follows the result line
echo "$out" | grep -q '\*\*\* TEST PASSED \*\*\*'

/* source/sd_block_reader.sv */
/*
 * SD single block reader
 * Fetches one sector from RAM and sends it on dat[0]
 * framed by a start bit, CRC16 and end bit
 */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_block_reader
    import sd_proto_pkg::*;
    import sd_card_pkg::*;
(
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       read_start,
    input  cmd_arg_t   read_sector,
    output logic       read_active,
    output logic       rdreq,
    output ram_addr_t  rdaddr,
    input  ram_word_t  rddata,
    output logic [3:0] dat_out,
    output logic       dat_oe
);

    localparam logic [12:0] BLOCK_BITS  = 13'(`SD_BLOCK_BYTES * 8);
    localparam logic [12:0] START_BIT   = 13'(`SD_DATA_GAP);
    localparam logic [12:0] DATA_FIRST  = START_BIT + 13'd1;
    localparam logic [12:0] CRC_FIRST   = DATA_FIRST + BLOCK_BITS;
    localparam logic [12:0] END_BIT     = CRC_FIRST + 13'd16;
    localparam logic [12:0] FETCH_FIRST = DATA_FIRST - 13'd2;   // One cycle RAM latency

    logic [12:0] cnt;
    logic [12:0] data_idx;
    logic [12:0] fetch_idx;
    cmd_arg_t    sector;
    ram_word_t   word;
    logic [15:0] word_swapped;
    logic        fetched;
    logic        data_bit;
    logic        dat0;
    crc16_t      crc;

    assign data_idx  = cnt - DATA_FIRST;
    assign fetch_idx = cnt - FETCH_FIRST;

    // Low byte first, MSB first within each byte
    assign word_swapped = {word[7:0], word[15:8]};
    assign data_bit     = word_swapped[~data_idx[3:0]];

    assign rdreq  = read_active && cnt >= FETCH_FIRST && fetch_idx < BLOCK_BITS
                 && fetch_idx[3:0] == 4'd0;
    assign rdaddr = {sector, fetch_idx[11:4]};

    always_comb begin
        if (!read_active || cnt < START_BIT) begin
            dat0 = 1'b1;
        end else if (cnt < DATA_FIRST) begin
            dat0 = 1'b0;
        end else if (cnt < CRC_FIRST) begin
            dat0 = data_bit;
        end else if (cnt < END_BIT) begin
            dat0 = crc[15];
        end else begin
            dat0 = 1'b1;
        end
    end

    assign dat_out = {3'b111, dat0};
    assign dat_oe  = read_active;

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            read_active <= 1'b0;
            cnt         <= 13'd0;
            fetched     <= 1'b0;
        end else begin
            fetched <= rdreq;
            if (!read_active) begin
                read_active <= read_start;
                cnt         <= 13'd0;
            end else begin
                cnt <= cnt + 13'd1;
                if (cnt == END_BIT) begin
                    read_active <= 1'b0;
                end
            end
        end
    end

    // Data path -------------
    always_ff @(posedge sdclk) begin
        if (read_start && !read_active) begin
            sector <= read_sector;
        end
        if (fetched) begin
            word <= rddata;
        end
        if (!read_active) begin
            crc <= '0;
        end else if (cnt >= DATA_FIRST && cnt < CRC_FIRST) begin
            crc <= crc16_next(crc, data_bit);
        end else if (cnt >= CRC_FIRST) begin
            crc <= crc << 1;                     // Shift out MSB first
        end
    end

endmodule

/* source/sd_card_ctrl.sv */
/*
 * SD card controller
 * Decodes host commands, keeps card state and status,
 * and starts responses and single block reads
 */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_card_ctrl
    import sd_proto_pkg::*;
    import sd_card_pkg::*;
(
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       cmd_valid,
    input  cmd_index_t cmd_index,
    input  cmd_arg_t   cmd_arg,
    sd_resp_if.ctrl    resp,
    input  logic       read_active,
    output logic       read_start,
    output cmd_arg_t   read_sector
);

    card_state_t   state;
    card_state_t   base_state;
    card_state_t   state_n;
    logic          app_flag;        // Last command was CMD55
    logic          illegal;
    logic          ready_for_data;
    logic          app_now;
    logic          rca_match;
    card_status_t  status;
    logic [15:0]   status_short;
    logic          legal;
    logic          respond;
    logic          read_n;
    resp_kind_t    kind_n;
    resp_payload_t payload_n;

    assign rca_match = (cmd_arg[31:16] == `SD_RCA);
    assign app_now   = (cmd_index == 6'd55 && (rca_match || cmd_arg[31:16] == 16'd0))
                    || (cmd_index == 6'd41 && app_flag);

    assign status = {9'd0, illegal, 9'd0, state, ready_for_data, 2'b00, app_now, 5'd0};
    assign status_short = {status[23:22], status[19], status[12:0]};  // R6 layout

    // State follows the data line while no command intervenes
    assign base_state = read_active      ? DATA :
                        (state == DATA)  ? TRAN : state;

    // Command table ---------
    always_comb begin
        legal     = 1'b1;
        respond   = 1'b1;
        read_n    = 1'b0;
        kind_n    = R1;
        payload_n = {88'd0, status};
        state_n   = base_state;
        case (cmd_index)
            6'd0: begin
                respond = 1'b0;
                state_n = IDLE;
            end
            6'd2: begin
                kind_n    = R2;
                payload_n = `SD_CID;
                state_n   = IDENT;
            end
            6'd3: begin
                kind_n    = R6;
                payload_n = {88'd0, `SD_RCA, status_short};
                state_n   = STBY;
            end
            6'd7: begin
                respond = rca_match;             // Deselect is silent
                state_n = rca_match ? TRAN : STBY;
            end
            6'd8: begin
                kind_n    = R7;
                payload_n = {88'd0, 20'd0, 4'd1, cmd_arg[7:0]};
            end
            6'd13: legal = rca_match;
            6'd17: begin
                legal  = (state == TRAN);
                read_n = 1'b1;
            end
            6'd41: begin
                legal     = app_flag;
                kind_n    = R3;
                payload_n = {88'd0, `SD_OCR};
                if (state == IDLE) begin
                    state_n = READY;
                end
            end
            6'd55: legal = app_now;
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            state          <= IDLE;
            app_flag       <= 1'b0;
            illegal        <= 1'b0;
            ready_for_data <= 1'b1;
            resp.start     <= 1'b0;
            read_start     <= 1'b0;
        end else begin
            ready_for_data <= !read_active;
            resp.start     <= cmd_valid && legal && respond;
            read_start     <= cmd_valid && legal && read_n;
            state          <= (cmd_valid && legal) ? state_n : base_state;
            if (cmd_valid) begin
                app_flag <= legal && (cmd_index == 6'd55);
                if (!legal) begin
                    illegal <= 1'b1;
                end else if (respond || cmd_index == 6'd0) begin
                    illegal <= 1'b0;             // Reported, now cleared
                end
            end
        end
    end

    always_ff @(posedge sdclk) begin
        if (cmd_valid) begin
            resp.kind    <= kind_n;
            resp.index   <= cmd_index;
            resp.payload <= payload_n;
            read_sector  <= cmd_arg;
        end
    end

endmodule

/* source/sd_card_pkg.sv */
/*
 * SD card side types
 * Card state encoding, status word and RAM port widths
 */
package sd_card_pkg;

    // Encoding as in the current_state field of the card status
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        READY = 4'd1,
        IDENT = 4'd2,
        STBY  = 4'd3,
        TRAN  = 4'd4,
        DATA  = 4'd5
    } card_state_t;

    typedef logic [31:0] card_status_t;
    typedef logic [39:0] ram_addr_t;   // Word address, 256 words per sector
    typedef logic [15:0] ram_word_t;

endpackage

/* source/sd_cmd_receiver.sv */
/*
 * SD command receiver
 * Shifts in 48-bit host frames, checks framing and CRC7,
 * and presents the index and argument of a good frame
 */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_cmd_receiver
    import sd_proto_pkg::*;
(
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       cmd_in,
    input  logic       resp_busy,
    output logic       cmd_valid,
    output cmd_index_t cmd_index,
    output cmd_arg_t   cmd_arg
);

    localparam int N = `SD_FRAME_BITS;

    logic [N-1:0] frame;
    logic         framed;
    crc7_t        crc_calc;

    // CRC over start, transmission, index and argument
    always_comb begin
        crc_calc = '0;
        for (int i = N - 1; i >= 8; i--) begin
            crc_calc = crc7_next(crc_calc, frame[i]);
        end
    end

    assign framed    = !frame[N-1] && frame[N-2] && frame[0];
    assign cmd_valid = framed && (crc_calc == frame[7:1]);
    assign cmd_index = frame[N-3 -: 6];
    assign cmd_arg   = frame[N-9 -: 32];

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            frame <= '1;
        end else if (resp_busy || framed) begin
            frame <= '1;                       // Deaf while answering
        end else begin
            frame <= {frame[N-2:0], cmd_in};
        end
    end

endmodule

/* source/sd_fake_top.sv */
/*
 * Read-only SDHC card model, 1-bit bus
 * Command receiver, controller, response serializer and block reader
 */
`timescale 1ns/1ps

module sd_fake_top
    import sd_proto_pkg::*;
    import sd_card_pkg::*;
(
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       cmd_in,
    output logic       cmd_out,
    output logic       cmd_oe,
    output logic [3:0] dat_out,
    output logic       dat_oe,
    output logic       rdreq,
    output ram_addr_t  rdaddr,
    input  ram_word_t  rddata
);

    logic       cmd_valid;
    cmd_index_t cmd_index;
    cmd_arg_t   cmd_arg;
    logic       read_start;
    cmd_arg_t   read_sector;
    logic       read_active;

    sd_resp_if resp_if ();

    sd_cmd_receiver u_receiver (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .cmd_in       (cmd_in),
        .resp_busy    (resp_if.busy),
        .cmd_valid    (cmd_valid),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg)
    );

    sd_card_ctrl u_ctrl (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .cmd_valid    (cmd_valid),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .resp         (resp_if.ctrl),
        .read_active  (read_active),
        .read_start   (read_start),
        .read_sector  (read_sector)
    );

    sd_resp_serializer u_serializer (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .resp         (resp_if.ser),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe)
    );

    sd_block_reader u_reader (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .read_start   (read_start),
        .read_sector  (read_sector),
        .read_active  (read_active),
        .rdreq        (rdreq),
        .rdaddr       (rdaddr),
        .rddata       (rddata),
        .dat_out      (dat_out),
        .dat_oe       (dat_oe)
    );

endmodule

/* source/sd_proto_pkg.sv */
/*
 * SD bus protocol types
 * Command fields, CRC widths, response kinds and the CRC update steps
 */
package sd_proto_pkg;

    typedef logic [5:0]   cmd_index_t;
    typedef logic [31:0]  cmd_arg_t;
    typedef logic [6:0]   crc7_t;
    typedef logic [15:0]  crc16_t;
    typedef logic [119:0] resp_payload_t;

    typedef enum logic [2:0] {R1, R2, R3, R6, R7} resp_kind_t;

    // x^7 + x^3 + 1, one bit per call
    function automatic crc7_t crc7_next(crc7_t crc, logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], fb} ^ {3'b000, fb, 3'b000};
    endfunction

    // x^16 + x^12 + x^5 + 1
    function automatic crc16_t crc16_next(crc16_t crc, logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:0], fb} ^ {3'b000, fb, 6'b000000, fb, 5'b00000};
    endfunction

endpackage

/* source/sd_resp_if.sv */
/*
 * Response request channel
 * Card controller asks the serializer to send one response frame
 */
`timescale 1ns/1ps

interface sd_resp_if
    import sd_proto_pkg::*;
();

    logic          start;    // One-cycle request, only while busy is low
    resp_kind_t    kind;
    cmd_index_t    index;
    resp_payload_t payload;  // Short kinds use the low 32 bits
    logic          busy;

    modport ctrl (
        output start,
        output kind,
        output index,
        output payload,
        input  busy
    );

    modport ser (
        input  start,
        input  kind,
        input  index,
        input  payload,
        output busy
    );

endinterface

/* source/sd_resp_serializer.sv */
/*
 * SD response serializer
 * Sends one response frame on the command line with its CRC7
 */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_resp_serializer
    import sd_proto_pkg::*;
(
    input  logic   sdclk,
    input  logic   rstn_sdclk_p,
    sd_resp_if.ser resp,
    output logic   cmd_out,
    output logic   cmd_oe
);

    localparam logic [7:0] GAP = 8'(`SD_RESP_GAP);

    logic         busy;
    logic [7:0]   cnt;
    logic [7:0]   body_end;     // Past the last payload bit
    logic [7:0]   crc_end;      // End bit position
    logic [127:0] shreg;
    logic         force_ones;
    crc7_t        crc;
    cmd_index_t   index_sent;

    assign index_sent = (resp.kind == R2) ? 6'd0  :
                        (resp.kind == R3) ? 6'h3f : resp.index;
    assign crc_end    = body_end + 8'd7;
    assign resp.busy  = busy;
    assign cmd_oe     = busy;

    always_comb begin
        if (!busy || cnt < GAP) begin
            cmd_out = 1'b1;
        end else if (cnt < body_end) begin
            cmd_out = shreg[127];
        end else if (cnt < crc_end) begin
            cmd_out = force_ones | crc[6];
        end else begin
            cmd_out = 1'b1;
        end
    end

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            busy <= 1'b0;
            cnt  <= 8'd0;
        end else if (!busy) begin
            busy <= resp.start;
            cnt  <= 8'd0;
        end else begin
            cnt <= cnt + 8'd1;
            if (cnt == crc_end) begin
                busy <= 1'b0;
            end
        end
    end

    // Frame register --------
    always_ff @(posedge sdclk) begin
        if (!busy) begin
            crc        <= '0;
            force_ones <= (resp.kind == R3);
            if (resp.kind == R2) begin
                shreg    <= {2'b00, index_sent, resp.payload};
                body_end <= GAP + 8'd128;
            end else begin
                shreg    <= {2'b00, index_sent, resp.payload[31:0], 88'd0};
                body_end <= GAP + 8'd40;
            end
        end else if (cnt >= GAP && cnt < body_end) begin
            shreg <= shreg << 1;
            crc   <= crc7_next(crc, shreg[127]);
        end else if (cnt >= body_end) begin
            crc <= crc << 1;
        end
    end

endmodule

/* source/sd_settings.svh */
/*
 * SD card model constants
 * Frame lengths, bus gaps, block size and the fixed card registers
 */
`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

// Bus framing ------------
`define SD_FRAME_BITS   48
`define SD_RESP_GAP     2
`define SD_DATA_GAP     16
`define SD_BLOCK_BYTES  512

// Card registers ---------
`define SD_RCA  16'h0013
// Not busy, CCS set, full voltage window
`define SD_OCR  32'hc0ff_8000
`define SD_CID  120'h02544d53_41303847_14394a67_c700e4

`endif
